/* rtl/stepctl_pkg.sv */
package stepctl_pkg;

  // SPI word and every 64-bit move quantity
  localparam int WORD_W  = 64;
  localparam int DIV_W   = 24;  // Tick divisor
  localparam int MICRO_W = 3;   // Microstep shift

  // Command headers, top byte of a header word
  localparam logic [7:0] HDR_MOVE    = 8'h01;  // Coordinated move, dir in bit 0
  localparam logic [7:0] HDR_CLKDIV  = 8'h03;
  localparam logic [7:0] HDR_MICRO   = 8'h04;
  localparam logic [7:0] HDR_VERSION = 8'hfe;

  // Version bytes, reply bits [23:16], [15:8], [7:0]
  localparam logic [7:0] VERSION_MAJOR = 8'd0;
  localparam logic [7:0] VERSION_MINOR = 8'd2;
  localparam logic [7:0] VERSION_PATCH = 8'd1;

  // Taken off the accumulator per step
  // Slightly under the signed maximum so the sum keeps some headroom
  localparam logic [WORD_W-1:0] STEP_THRESHOLD = 64'h7fff_ffff_ffff_ff9b;

endpackage

/* rtl/spi_word_port.sv */
`timescale 1ns/1ps

module spi_word_port (
  input  logic                           CLK,
  input  logic                           rst,
  input  logic                           sck,
  input  logic                           cs_n,
  input  logic                           copi,
  input  logic [stepctl_pkg::WORD_W-1:0] tx_word,
  output logic                           cipo,
  output logic [stepctl_pkg::WORD_W-1:0] rx_word,
  output logic                           word_valid
);
  import stepctl_pkg::*;

  localparam int CNT_W = $clog2(WORD_W);

  logic [1:0]        sck_sync;
  logic [1:0]        cs_sync;
  logic [1:0]        copi_sync;
  logic              sck_q;     // Previous synced sck
  logic              cs_q;
  logic              sck_rise;
  logic              sck_fall;
  logic              cs_fall;
  logic [CNT_W-1:0]  bit_cnt;
  logic [WORD_W-1:0] rx_sr;
  logic [WORD_W-1:0] tx_sr;

  // Two-flop synchronizers plus one delay flop for edge detect
  always_ff @(posedge CLK) begin
    if (rst) begin
      sck_sync <= '0;
      cs_sync  <= '1;  // Deselected
      sck_q    <= 1'b0;
      cs_q     <= 1'b1;
    end else begin
      sck_sync <= {sck_sync[0], sck};
      cs_sync  <= {cs_sync[0], cs_n};
      sck_q    <= sck_sync[1];
      cs_q     <= cs_sync[1];
    end
  end

  always_ff @(posedge CLK) begin
    copi_sync <= {copi_sync[0], copi};  // Data pin, same latency as sck
  end

  assign sck_rise = sck_sync[1] & ~sck_q & ~cs_sync[1];
  assign sck_fall = ~sck_sync[1] & sck_q & ~cs_sync[1];
  assign cs_fall  = ~cs_sync[1] & cs_q;

  always_ff @(posedge CLK) begin
    if (rst) begin
      bit_cnt    <= '0;
      tx_sr      <= '0;
      word_valid <= 1'b0;
    end else begin
      word_valid <= 1'b0;
      if (cs_fall) begin
        tx_sr   <= tx_word;  // Reply for this frame
        bit_cnt <= '0;
      end else if (sck_rise) begin
        bit_cnt    <= bit_cnt + 1'b1;  // Wraps after a full word
        word_valid <= (bit_cnt == CNT_W'(WORD_W - 1));
      end else if (sck_fall) begin
        tx_sr <= {tx_sr[WORD_W-2:0], 1'b0};  // Mode 0, next bit out on falling edge
      end
    end
  end

  // MSB first in
  always_ff @(posedge CLK) begin
    if (sck_rise) rx_sr <= {rx_sr[WORD_W-2:0], copi_sync[1]};
  end

  assign rx_word = rx_sr;  // Complete while word_valid is high
  assign cipo    = tx_sr[WORD_W-1];

endmodule

/* rtl/cmd_decoder.sv */
`timescale 1ns/1ps

module cmd_decoder #(
  parameter int unsigned CLKDIV_RESET = 40,
  parameter int unsigned MICRO_MAX    = 4
) (
  input  logic                                  CLK,
  input  logic                                  rst,
  input  logic        [stepctl_pkg::WORD_W-1:0] rx_word,
  input  logic                                  word_valid,
  input  logic signed [stepctl_pkg::WORD_W-1:0] enc_count,
  input  logic        [stepctl_pkg::WORD_W-1:0] last_ticks,
  input  logic        [stepctl_pkg::WORD_W-1:0] last_steps,
  output logic        [stepctl_pkg::WORD_W-1:0] tx_word,
  output logic                                  start,
  output logic        [stepctl_pkg::WORD_W-1:0] duration,
  output logic signed [stepctl_pkg::WORD_W-1:0] increment,
  output logic signed [stepctl_pkg::WORD_W-1:0] increment_inc,
  output logic        [stepctl_pkg::DIV_W-1:0]  clk_div,
  output logic                                  dir,
  output logic        [stepctl_pkg::MICRO_W-1:0] microsteps
);
  import stepctl_pkg::*;

  logic               in_msg;     // Header taken, more words expected
  logic [7:0]         hdr_q;      // Header of the open message
  logic [1:0]         word_idx;   // Word number after the header
  logic [7:0]         rx_hdr;
  logic [MICRO_W-1:0] micro_req;

  assign rx_hdr    = rx_word[WORD_W-1 -: 8];
  assign micro_req = rx_word[MICRO_W-1:0];

  // Move words: duration, increment, increment of increment
  always_ff @(posedge CLK) begin
    if (word_valid && in_msg && hdr_q == HDR_MOVE) begin
      case (word_idx)
        2'd0:    duration      <= rx_word;
        2'd1:    increment     <= rx_word;
        default: increment_inc <= rx_word;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (rst) begin
      in_msg     <= 1'b0;
      hdr_q      <= '0;
      word_idx   <= '0;
      start      <= 1'b0;
      tx_word    <= '0;
      clk_div    <= DIV_W'(CLKDIV_RESET);
      dir        <= 1'b0;
      microsteps <= '0;
    end else begin
      start <= 1'b0;
      if (word_valid) begin
        tx_word <= enc_count;  // Default reply
        if (!in_msg) begin
          hdr_q    <= rx_hdr;
          word_idx <= '0;
          case (rx_hdr)
            HDR_MOVE: begin
              in_msg  <= 1'b1;
              dir     <= rx_word[0];
              tx_word <= last_ticks;  // Ticks of the previous move
            end
            HDR_CLKDIV: clk_div <= rx_word[DIV_W-1:0];
            HDR_MICRO: begin
              // Clamp to what the phase counter can shift
              microsteps <= (micro_req > MICRO_W'(MICRO_MAX)) ? MICRO_W'(MICRO_MAX)
                                                              : micro_req;
            end
            HDR_VERSION: begin
              in_msg  <= 1'b1;  // Skip one filler word
              tx_word <= {{(WORD_W-24){1'b0}}, VERSION_MAJOR, VERSION_MINOR, VERSION_PATCH};
            end
            default: ;  // Unknown, dropped
          endcase
        end else begin
          word_idx <= word_idx + 1'b1;
          if (hdr_q == HDR_MOVE) begin
            if (word_idx == 2'd0) tx_word <= last_steps;
            if (word_idx == 2'd2) begin
              in_msg <= 1'b0;
              start  <= 1'b1;  // Move complete, restarts any running one
            end
          end else begin
            in_msg <= 1'b0;  // Version filler consumed
          end
        end
      end
    end
  end

endmodule

/* rtl/step_profile.sv */
`timescale 1ns/1ps

module step_profile (
  input  logic                                  CLK,
  input  logic                                  rst,
  input  logic                                  start,
  input  logic        [stepctl_pkg::WORD_W-1:0] duration,
  input  logic signed [stepctl_pkg::WORD_W-1:0] increment,
  input  logic signed [stepctl_pkg::WORD_W-1:0] increment_inc,
  input  logic        [stepctl_pkg::DIV_W-1:0]  clk_div,
  output logic                                  step,
  output logic                                  busy,
  output logic        [stepctl_pkg::WORD_W-1:0] last_ticks,
  output logic        [stepctl_pkg::WORD_W-1:0] last_steps
);
  import stepctl_pkg::*;

  logic        [DIV_W-1:0]  clk_cnt;  // Cycles inside the current tick
  logic                     tick;
  logic signed [WORD_W-1:0] inc_q;    // Working increment
  logic signed [WORD_W-1:0] inc_now;
  logic signed [WORD_W-1:0] acc_q;    // Substep accumulator
  logic signed [WORD_W-1:0] acc_sum;

  // Divisor of 0 or 1 ticks every cycle
  assign tick = busy && (clk_cnt + 1'b1 >= clk_div);

  // First tick loads the increment, later ticks accelerate
  assign inc_now = (last_ticks == '0) ? increment : inc_q + increment_inc;
  assign acc_sum = acc_q + inc_now;
  assign step    = tick && (acc_sum > 0);

  always_ff @(posedge CLK) begin
    if (rst) begin
      busy       <= 1'b0;
      clk_cnt    <= '0;
      acc_q      <= '0;
      last_ticks <= '0;
      last_steps <= '0;
    end else if (start) begin
      busy       <= (duration != '0);  // Empty move ends at once
      clk_cnt    <= '0;
      acc_q      <= '0;
      last_ticks <= '0;
      last_steps <= '0;
    end else if (tick) begin
      clk_cnt    <= '0;
      last_ticks <= last_ticks + 1'b1;
      if (last_ticks + 1'b1 == duration) busy <= 1'b0;
      if (step) begin
        acc_q      <= acc_sum - $signed(STEP_THRESHOLD);
        last_steps <= last_steps + 1'b1;
      end else begin
        acc_q <= acc_sum;
      end
    end else if (busy) begin
      clk_cnt <= clk_cnt + 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (tick) inc_q <= inc_now;
  end

endmodule

/* rtl/hbridge_phase.sv */
`timescale 1ns/1ps

module hbridge_phase #(
  parameter int unsigned MICRO_MAX = 4
) (
  input  logic                            CLK,
  input  logic                            rst,
  input  logic                            step,
  input  logic                            dir,
  input  logic [stepctl_pkg::MICRO_W-1:0] microsteps,
  output logic                            phase_a1,
  output logic                            phase_a2,
  output logic                            phase_b1,
  output logic                            phase_b2
);
  import stepctl_pkg::*;

  localparam int POS_W = MICRO_MAX + 2;  // Room for the top full-step index

  logic [POS_W-1:0]   pos_q;  // Microstep position, wraps
  logic [1:0]         idx;    // Full-step index

  always_ff @(posedge CLK) begin
    if (rst) begin
      pos_q <= '0;
    end else if (step) begin
      pos_q <= dir ? pos_q + 1'b1 : pos_q - 1'b1;  // dir high counts up
    end
  end

  // Shift arrives clamped to MICRO_MAX, select stays inside pos_q
  assign idx = pos_q[microsteps +: 2];

  // Two phases on, A+B+ A-B+ A-B- A+B-
  always_comb begin
    case (idx)
      2'd0:    {phase_a1, phase_a2, phase_b1, phase_b2} = 4'b1010;
      2'd1:    {phase_a1, phase_a2, phase_b1, phase_b2} = 4'b0110;
      2'd2:    {phase_a1, phase_a2, phase_b1, phase_b2} = 4'b0101;
      default: {phase_a1, phase_a2, phase_b1, phase_b2} = 4'b1001;
    endcase
  end

endmodule

/* rtl/quad_decoder.sv */
`timescale 1ns/1ps

module quad_decoder (
  input  logic                                  CLK,
  input  logic                                  rst,
  input  logic                                  enc_a,
  input  logic                                  enc_b,
  output logic signed [stepctl_pkg::WORD_W-1:0] enc_count,
  output logic                                  enc_fault
);
  import stepctl_pkg::*;

  logic [1:0]               a_sync;
  logic [1:0]               b_sync;
  logic                     a_q;    // Last sample
  logic                     b_q;
  logic                     a_chg;
  logic                     b_chg;
  logic signed [WORD_W-1:0] delta;

  // Pipeline runs through reset, so the first sample after it is not an edge
  always_ff @(posedge CLK) begin
    a_sync <= {a_sync[0], enc_a};
    b_sync <= {b_sync[0], enc_b};
    a_q    <= a_sync[1];
    b_q    <= b_sync[1];
  end

  assign a_chg = a_sync[1] ^ a_q;
  assign b_chg = b_sync[1] ^ b_q;

  // A leading B: new A differs from old B, count up
  assign delta = (a_sync[1] ^ b_q) ? WORD_W'(1) : '1;

  always_ff @(posedge CLK) begin
    if (rst) begin
      enc_count <= '0;
      enc_fault <= 1'b0;
    end else if (a_chg && b_chg) begin
      enc_fault <= 1'b1;  // Skipped a Gray state, count held
    end else if (a_chg || b_chg) begin
      enc_count <= enc_count + delta;  // x4, every edge counts
    end
  end

endmodule

/* rtl/stepctl_top.sv */
`timescale 1ns/1ps

module stepctl_top #(
  parameter int unsigned CLKDIV_RESET = 40,
  parameter int unsigned MICRO_MAX    = 4
) (
  input  logic CLK,
  input  logic rst,
  input  logic sck,
  input  logic cs_n,
  input  logic copi,
  output logic cipo,
  output logic phase_a1,
  output logic phase_a2,
  output logic phase_b1,
  output logic phase_b2,
  output logic step,
  output logic dir,
  output logic busy,
  input  logic enc_a,
  input  logic enc_b,
  output logic enc_fault
);
  import stepctl_pkg::*;

  logic        [WORD_W-1:0]  rx_word;
  logic        [WORD_W-1:0]  tx_word;
  logic                      word_valid;
  logic                      start;
  logic        [WORD_W-1:0]  duration;
  logic signed [WORD_W-1:0]  increment;
  logic signed [WORD_W-1:0]  increment_inc;
  logic        [DIV_W-1:0]   clk_div;
  logic        [MICRO_W-1:0] microsteps;
  logic        [WORD_W-1:0]  last_ticks;
  logic        [WORD_W-1:0]  last_steps;
  logic signed [WORD_W-1:0]  enc_count;

  spi_word_port u_spi (
    .CLK(CLK), .rst(rst), .sck(sck), .cs_n(cs_n), .copi(copi),
    .tx_word(tx_word), .cipo(cipo), .rx_word(rx_word), .word_valid(word_valid)
  );

  cmd_decoder #(.CLKDIV_RESET(CLKDIV_RESET), .MICRO_MAX(MICRO_MAX)) u_dec (
    .CLK(CLK), .rst(rst), .rx_word(rx_word), .word_valid(word_valid),
    .enc_count(enc_count), .last_ticks(last_ticks), .last_steps(last_steps),
    .tx_word(tx_word), .start(start), .duration(duration), .increment(increment),
    .increment_inc(increment_inc), .clk_div(clk_div), .dir(dir), .microsteps(microsteps)
  );

  step_profile u_prof (
    .CLK(CLK), .rst(rst), .start(start), .duration(duration), .increment(increment),
    .increment_inc(increment_inc), .clk_div(clk_div), .step(step), .busy(busy),
    .last_ticks(last_ticks), .last_steps(last_steps)
  );

  hbridge_phase #(.MICRO_MAX(MICRO_MAX)) u_phase (
    .CLK(CLK), .rst(rst), .step(step), .dir(dir), .microsteps(microsteps),
    .phase_a1(phase_a1), .phase_a2(phase_a2), .phase_b1(phase_b1), .phase_b2(phase_b2)
  );

  quad_decoder u_enc (
    .CLK(CLK), .rst(rst), .enc_a(enc_a), .enc_b(enc_b),
    .enc_count(enc_count), .enc_fault(enc_fault)
  );

endmodule

/* dv/stepctl_sva.sv */
`timescale 1ns/1ps

module stepctl_sva (
  input logic CLK,
  input logic rst,
  input logic step,
  input logic busy,
  input logic phase_a1,
  input logic phase_a2,
  input logic phase_b1,
  input logic phase_b2
);

  // Steps only inside a running move
  a_step_busy: assert property (@(posedge CLK) disable iff (rst) step |-> busy)
    else $error("step pulse while busy is low");

  a_step_width: assert property (@(posedge CLK) disable iff (rst) step |=> !step)
    else $error("step pulse wider than one cycle");

  // Both legs of one bridge high would short the supply
  a_bridge_a: assert property (@(posedge CLK) disable iff (rst) !(phase_a1 && phase_a2))
    else $error("bridge A drives both outputs high");

  a_bridge_b: assert property (@(posedge CLK) disable iff (rst) !(phase_b1 && phase_b2))
    else $error("bridge B drives both outputs high");

endmodule

bind stepctl_top stepctl_sva u_sva (
  .CLK(CLK), .rst(rst), .step(step), .busy(busy),
  .phase_a1(phase_a1), .phase_a2(phase_a2), .phase_b1(phase_b1), .phase_b2(phase_b2)
);

/* dv/stepctl_tb.sv */
`timescale 1ns/1ps

module stepctl_tb;
  import stepctl_pkg::*;

  localparam int CLKDIV_RESET = 2;
  localparam int MICRO_MAX    = 4;
  localparam int MOVE_TIMEOUT = 20000;  // Cycles allowed for one move
  localparam int WORD_TIMEOUT = 16;     // Cycles from last sck edge to word_valid

  logic CLK = 1'b0;
  logic rst;
  logic sck;
  logic cs_n;
  logic copi;
  logic cipo;
  logic phase_a1;
  logic phase_a2;
  logic phase_b1;
  logic phase_b2;
  logic step;
  logic dir;
  logic busy;
  logic enc_a;
  logic enc_b;
  logic enc_fault;

  logic [15:0] lfsr_q = 16'd71;  // Seed
  int          errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          words_seen = 0;   // word_valid pulses so far
  int          moves_done = 0;   // Falling edges of busy
  logic        busy_q = 1'b0;
  logic [63:0] step_cnt = '0;
  logic [63:0] exp_steps = '0;   // Reference count for the running move
  longint      net_pos = 0;      // Microsteps, dir high counts up
  longint      enc_net = 0;
  logic [1:0]  enc_state = '0;   // Gray position of A/B

  always #10 CLK = ~CLK;

  stepctl_top #(.CLKDIV_RESET(CLKDIV_RESET), .MICRO_MAX(MICRO_MAX)) u_dut (
    .CLK(CLK), .rst(rst), .sck(sck), .cs_n(cs_n), .copi(copi), .cipo(cipo),
    .phase_a1(phase_a1), .phase_a2(phase_a2), .phase_b1(phase_b1), .phase_b2(phase_b2),
    .step(step), .dir(dir), .busy(busy), .enc_a(enc_a), .enc_b(enc_b), .enc_fault(enc_fault)
  );

  // 16-bit Galois LFSR, one step per bit taken
  function automatic logic [63:0] random_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hb400) : (lfsr_q >> 1);
      v = {v[62:0], lfsr_q[0]};
    end
    return v;
  endfunction

  // Accumulator model of one move, steps expected after dur ticks
  function automatic logic [63:0] expected_steps(input logic [63:0] dur,
                                                 input logic [63:0] inc0,
                                                 input logic [63:0] dinc);
    longint      acc;
    longint      inc;
    longint      sum;
    logic [63:0] n;
    acc = 0;
    inc = 0;
    n   = '0;
    for (logic [63:0] t = '0; t < dur; t = t + 64'd1) begin
      inc = (t == '0) ? $signed(inc0) : inc + $signed(dinc);  // Accelerate after tick 0
      sum = acc + inc;
      if (sum > 64'sd0) begin
        acc = sum - $signed(STEP_THRESHOLD);
        n   = n + 64'd1;
      end else begin
        acc = sum;
      end
    end
    return n;
  endfunction

  // A+B+ A-B+ A-B- A+B-, as {a1, a2, b1, b2}
  function automatic logic [3:0] coil_pattern(input longint pos, input int shift);
    longint p;
    p = pos >>> shift;
    case (p[1:0])
      2'd0:    return 4'b1010;
      2'd1:    return 4'b0110;
      2'd2:    return 4'b0101;
      default: return 4'b1001;
    endcase
  endfunction

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge CLK);
  endtask

  task automatic report_mismatch(input string what, input logic [63:0] got,
                                 input logic [63:0] exp);
    $display("FAIL at %0t ns: %s got %h expected %h", $time, what, got, exp);
    errors++;
  endtask

  task automatic end_test(input string name, input int errs_before);
    tests_run++;
    if (errors == errs_before) begin
      $display("test %s ok", name);
    end else begin
      tests_failed++;
      $display("test %s failed with %0d errors", name, errors - errs_before);
    end
  endtask

  // One SPI mode 0 frame, MSB first, 4-cycle half-periods
  task automatic exchange_word(input logic [63:0] tx, output logic [63:0] rx);
    int seen;
    int n;
    @(posedge CLK);  // Frame starts on a rising edge
    seen = words_seen;
    cs_n <= 1'b0;
    wait_cycles(8);  // Reply loads after cs_n sync
    for (int i = WORD_W - 1; i >= 0; i--) begin
      sck  <= 1'b0;
      copi <= tx[i];
      wait_cycles(3);
      @(negedge CLK) rx[i] = cipo;
      @(posedge CLK);
      sck <= 1'b1;
      wait_cycles(4);
    end
    sck <= 1'b0;
    n = 0;
    while (words_seen == seen && n < WORD_TIMEOUT) begin
      @(posedge CLK);
      n++;
    end
    if (words_seen == seen) begin
      $display("Timeout at %0t ns: no word_valid after word %h", $time, tx);
      errors++;
    end
    wait_cycles(2);
    cs_n <= 1'b1;
    wait_cycles(6);
  endtask

  // Unknown header gets the default reply, read out on the next frame
  task automatic read_count(output logic [63:0] r);
    exchange_word(64'd0, r);
    exchange_word(64'd0, r);
  endtask

  task automatic run_move(input logic d, input logic [63:0] dur, input logic [63:0] inc0,
                          input logic [63:0] dinc, output logic [63:0] r_ticks,
                          output logic [63:0] r_steps);
    logic [63:0] r;
    int          done0;
    int          n;
    exp_steps = expected_steps(dur, inc0, dinc);
    done0     = moves_done;
    exchange_word({HDR_MOVE, 55'd0, d}, r);
    if (dir !== d) report_mismatch("move dir", 64'(dir), 64'(d));
    exchange_word(dur, r_ticks);   // Previous move ticks
    exchange_word(inc0, r_steps);  // Previous move steps
    exchange_word(dinc, r);
    n = 0;
    while (moves_done == done0 && n < MOVE_TIMEOUT) begin
      @(posedge CLK);
      n++;
    end
    if (moves_done == done0) begin
      $display("Timeout at %0t ns: busy never fell after the move", $time);
      errors++;
    end
    net_pos = d ? net_pos + longint'(exp_steps) : net_pos - longint'(exp_steps);
  endtask

  task automatic check_coils(input int shift_req);
    int         shift;
    logic [3:0] exp;
    shift = (shift_req > MICRO_MAX) ? MICRO_MAX : shift_req;  // Clamp
    @(negedge CLK);
    exp = coil_pattern(net_pos, shift);
    if ({phase_a1, phase_a2, phase_b1, phase_b2} !== exp) begin
      report_mismatch($sformatf("coils at shift %0d", shift_req),
                      64'({phase_a1, phase_a2, phase_b1, phase_b2}), 64'(exp));
    end
  endtask

  task automatic drive_encoder(input int count, input logic fwd);
    for (int i = 0; i < count; i++) begin
      enc_state = fwd ? enc_state + 2'd1 : enc_state - 2'd1;
      enc_net   = fwd ? enc_net + 1 : enc_net - 1;
      @(posedge CLK);
      enc_a <= (enc_state == 2'd1) || (enc_state == 2'd2);  // 00 10 11 01
      enc_b <= enc_state[1];
      wait_cycles(5);
    end
  endtask

  // Word and step monitors, compare at the end of each move
  always @(negedge CLK) begin
    if (u_dut.word_valid) words_seen++;
    if (busy && !busy_q) step_cnt = '0;
    if (step) step_cnt = step_cnt + 64'd1;
    if (busy_q && !busy) begin
      if (step_cnt !== exp_steps) report_mismatch("move step count", step_cnt, exp_steps);
      moves_done++;
    end
    busy_q = busy;
  end

  initial begin
    logic [63:0] r;
    logic [63:0] r_ticks;
    logic [63:0] r_steps;
    logic [63:0] dur1;
    logic [63:0] steps1;
    logic [63:0] dur;
    int          e0;
    int          n_fwd;
    int          n_rev;
    rst   = 1'b1;
    sck   = 1'b0;
    cs_n  = 1'b1;
    copi  = 1'b0;
    enc_a = 1'b0;
    enc_b = 1'b0;
    wait_cycles(16);
    rst <= 1'b0;
    wait_cycles(4);

    e0 = errors;
    exchange_word({HDR_VERSION, 56'd0}, r);
    exchange_word(64'd0, r);  // Filler carries the version out
    if (r !== {40'd0, VERSION_MAJOR, VERSION_MINOR, VERSION_PATCH}) begin
      report_mismatch("version reply", r, {40'd0, VERSION_MAJOR, VERSION_MINOR, VERSION_PATCH});
    end
    end_test("version", e0);

    e0 = errors;
    exchange_word({HDR_CLKDIV, 56'd3}, r);
    exchange_word({HDR_MICRO, 53'd0, 3'd1}, r);
    dur1 = 64'd40 + random_bits(5);
    run_move(1'b1, dur1, random_bits(20) << 40, random_bits(16) << 40, r_ticks, r_steps);
    steps1 = exp_steps;
    dur    = 64'd40 + random_bits(5);
    run_move(1'b0, dur, random_bits(22) << 40, random_bits(16) << 40, r_ticks, r_steps);
    end_test("move_steps", e0);

    e0 = errors;
    if (r_ticks !== dur1) report_mismatch("ticks readback", r_ticks, dur1);
    if (r_steps !== steps1) report_mismatch("steps readback", r_steps, steps1);
    end_test("readback", e0);

    e0 = errors;
    check_coils(1);
    exchange_word({HDR_MICRO, 53'd0, 3'd7}, r);  // Above MICRO_MAX
    check_coils(7);
    end_test("coils", e0);

    e0 = errors;
    n_fwd = 8 + int'(random_bits(5));
    n_rev = 2 + int'(random_bits(3));
    drive_encoder(n_fwd, 1'b1);
    drive_encoder(n_rev, 1'b0);
    read_count(r);
    if (r !== 64'(enc_net)) report_mismatch("encoder count", r, 64'(enc_net));
    end_test("enc_count", e0);

    e0 = errors;
    enc_state = enc_state + 2'd2;  // Both lines flip at once
    @(posedge CLK);
    enc_a <= ~enc_a;
    enc_b <= ~enc_b;
    wait_cycles(5);
    @(negedge CLK);
    if (enc_fault !== 1'b1) report_mismatch("fault after jump", 64'(enc_fault), 64'd1);
    read_count(r);
    if (r !== 64'(enc_net)) report_mismatch("count after jump", r, 64'(enc_net));
    @(negedge CLK);
    if (enc_fault !== 1'b1) report_mismatch("fault held", 64'(enc_fault), 64'd1);
    end_test("enc_fault", e0);

    $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

/* stepctl.f */
rtl/stepctl_pkg.sv
rtl/spi_word_port.sv
rtl/cmd_decoder.sv
rtl/step_profile.sv
rtl/hbridge_phase.sv
rtl/quad_decoder.sv
rtl/stepctl_top.sv
dv/stepctl_sva.sv
dv/stepctl_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= stepctl_tb
FILELIST  ?= stepctl.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= TB PASSED

SRCS := $(filter %.sv %.v,$(shell cat $(FILELIST)))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Fails unless the pass line shows up in the output
run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)
